/* fp_unit.f */
hw/fp_isa_pkg.sv
hw/fp_format_pkg.sv
hw/fp_decode.sv
hw/fp_cmp_sign.sv
hw/fp_scaleb.sv
hw/fp_f2i.sv
hw/fp_i2f.sv
hw/fp_writeback.sv
hw/fp_unit.sv
sim/fp_unit_tb.sv

/* hw/fp_cmp_sign.sv */
/*
 * Sign, classification and compare unit.
 * Produces absolute value, negation, sign, NaN and finite tests and the
 * compare word for one operand pair, registered in one cycle.
 */
module fp_cmp_sign
	import fp_format_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] abs_o,
	output logic [31:0] neg_o,
	output logic [31:0] sign_o,
	output logic [31:0] class_o,
	output logic [31:0] cmp_o
);

	logic a_s, b_s, a_nan, b_nan, a_zero, b_zero, a_fin;
	logic [30:0] a_mag, b_mag;
	logic unord, eq, lt;
	logic [31:0] sign_nxt;

	always_comb begin
		a_s    = a[FP_WID-1];
		b_s    = b[FP_WID-1];
		a_fin  = ~&a[30:MAN_WID];
		a_nan  = &a[30:MAN_WID] && |a[MAN_WID-1:0];
		b_nan  = &b[30:MAN_WID] && |b[MAN_WID-1:0];
		// A zero exponent covers subnormals too, which count as zero here
		a_zero = ~|a[30:MAN_WID];
		b_zero = ~|b[30:MAN_WID];
		a_mag  = a_zero ? 31'd0 : a[30:0];
		b_mag  = b_zero ? 31'd0 : b[30:0];
		unord  = a_nan | b_nan;

		// Plus and minus zero are equal since both magnitudes are cleared
		eq = (a_zero && b_zero) || (a_s == b_s && a_mag == b_mag);
		if (a_zero && b_zero)
			lt = 1'b0;
		else if (a_s != b_s)
			lt = a_s;
		else if (a_s)
			lt = a_mag > b_mag;
		else
			lt = a_mag < b_mag;

		// Sign gives a unit value with the operand's sign
		if (a_nan)
			sign_nxt = FP_QNAN;
		else if (a_zero)
			sign_nxt = {a_s, 31'd0};
		else
			sign_nxt = {a_s, FP_ONE_POS[30:0]};
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			abs_o   <= '0;
			neg_o   <= '0;
			sign_o  <= '0;
			class_o <= '0;
			cmp_o   <= '0;
		end else begin
			abs_o   <= {1'b0, a[30:0]};
			neg_o   <= {~a_s, a[30:0]};
			sign_o  <= sign_nxt;
			class_o <= {30'd0, a_fin, a_nan};
			// Any NaN kills the ordered results and raises unordered
			cmp_o   <= {27'd0, unord, 1'b0, ~unord & (lt | eq), ~unord & lt, ~unord & eq};
		end
	end

endmodule

/* hw/fp_decode.sv */
/*
 * Decode stage of the floating-point execute unit.
 * Turns the instruction word into an operation code and registers it
 * together with the operands, the rounding mode and the valid bit.
 */
module fp_decode
	import fp_isa_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        valid,
	input  instr_t      ir,
	input  logic [2:0]  rm,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic        d_valid,
	output op_sel_e     d_op,
	output logic [2:0]  d_rm,
	output logic [31:0] d_a,
	output logic [31:0] d_b
);

	op_sel_e op_nxt;

	// Only the two-operand opcode is known, everything else is OPS_NONE
	always_comb begin
		op_nxt = OPS_NONE;
		if (ir.f2.opcode == OP_FLT2) begin
			case (ir.f2.func2)
				FN_FLT1: begin
					// One-operand group, the rs2 slot now holds func1
					case (ir.f1.func1)
						FN_FABS:   op_nxt = OPS_FABS;
						FN_FNEG:   op_nxt = OPS_FNEG;
						FN_FSIGN:  op_nxt = OPS_FSIGN;
						FN_ISNAN:  op_nxt = OPS_ISNAN;
						FN_FINITE: op_nxt = OPS_FINITE;
						FN_FTOI:   op_nxt = OPS_FTOI;
						FN_ITOF:   op_nxt = OPS_ITOF;
						default:   op_nxt = OPS_NONE;
					endcase
				end
				FN_FSCALEB: op_nxt = OPS_FSCALEB;
				FN_FSEQ:    op_nxt = OPS_FSEQ;
				FN_FSNE:    op_nxt = OPS_FSNE;
				FN_FSLT:    op_nxt = OPS_FSLT;
				FN_FSLE:    op_nxt = OPS_FSLE;
				FN_FCMP:    op_nxt = OPS_FCMP;
				default:    op_nxt = OPS_NONE;
			endcase
		end
	end

	// Control state
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			d_valid <= 1'b0;
			d_op    <= OPS_NONE;
		end else begin
			d_valid <= valid;
			d_op    <= op_nxt;
		end
	end

	// Operands follow the op code without a reset
	always_ff @(posedge clk) begin
		d_rm <= rm;
		d_a  <= a;
		d_b  <= b;
	end

endmodule

/* hw/fp_f2i.sv */
/*
 * Float to signed 32-bit integer conversion.
 * Truncates toward zero and saturates out-of-range values and NaN.
 */
module fp_f2i
	import fp_format_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] a,
	output logic [31:0] o
);

	logic        a_s, a_nan;
	logic [7:0]  a_exp;
	logic [7:0]  ue;
	logic [31:0] sig;
	logic [31:0] mag;
	logic [31:0] res;

	always_comb begin
		a_s   = a[FP_WID-1];
		a_exp = a[30:MAN_WID];
		a_nan = &a_exp && |a[MAN_WID-1:0];
		// Unbiased exponent, only read once a_exp is at least the bias
		ue    = a_exp - 8'(EXP_BIAS);
		sig   = {8'd0, 1'b1, a[MAN_WID-1:0]};

		// Move the hidden one to bit ue, dropping the fraction bits
		if (ue >= 8'(MAN_WID))
			mag = sig << (ue - 8'(MAN_WID));
		else
			mag = sig >> (8'(MAN_WID) - ue);

		if (a_nan)
			res = INT_MAX;
		else if (a_exp < 8'(EXP_BIAS))
			// Magnitude below one, including zeros and subnormals
			res = '0;
		else if (ue >= 8'd31)
			// 2^31 and beyond saturate, which also catches infinity
			res = a_s ? INT_MIN : INT_MAX;
		else
			res = a_s ? (~mag + 32'd1) : mag;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			o <= '0;
		else
			o <= res;
	end

endmodule

/* hw/fp_format_pkg.sv */
/*
 * Single-precision number format for the floating-point execute unit.
 * Field widths, exponent bias, special encodings and rounding modes.
 */
package fp_format_pkg;

	// ==============================
	// Field layout
	// ==============================
	localparam int FP_WID   = 32;
	localparam int EXP_WID  = 8;
	localparam int MAN_WID  = 23;
	localparam int EXP_BIAS = 127;

	// ==============================
	// Special values
	// ==============================
	localparam logic [31:0] FP_QNAN    = 32'h7FC00000;
	localparam logic [31:0] FP_INF_POS = 32'h7F800000;
	// Plus one, used to build the result of the sign operation
	localparam logic [31:0] FP_ONE_POS = 32'h3F800000;
	localparam logic [31:0] INT_MAX    = 32'h7FFFFFFF;
	localparam logic [31:0] INT_MIN    = 32'h80000000;

	// Rounding modes as carried in the rm field
	localparam logic [2:0] RM_RNE = 3'd0;
	localparam logic [2:0] RM_RTZ = 3'd1;
	localparam logic [2:0] RM_RDN = 3'd2;
	localparam logic [2:0] RM_RUP = 3'd3;
	localparam logic [2:0] RM_RMM = 3'd4;

endpackage

/* hw/fp_i2f.sv */
/*
 * Signed 32-bit integer to float conversion.
 * Normalizes on the leading one and rounds the significand by the
 * rounding mode, using guard and sticky bits.
 */
module fp_i2f
	import fp_format_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] a,
	input  logic [2:0]  rm,
	output logic [31:0] o
);

	logic        s;
	logic [31:0] mag;
	logic [4:0]  lz;
	logic [31:0] norm;
	logic        lsb, guard, sticky, inc;
	logic [24:0] sum;
	logic        carry;
	logic [7:0]  e_fin;
	logic [31:0] res;

	always_comb begin
		s   = a[31];
		// The most negative value maps onto 2^31, which still fits unsigned
		mag = s ? (~a + 32'd1) : a;

		// Leading zero count, the highest set bit wins
		lz = 5'd0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i])
				lz = 5'(31 - i);
		end

		norm   = mag << lz;
		lsb    = norm[8];
		guard  = norm[7];
		sticky = |norm[6:0];

		case (rm)
			RM_RTZ:  inc = 1'b0;
			RM_RDN:  inc = s & (guard | sticky);
			RM_RUP:  inc = ~s & (guard | sticky);
			RM_RMM:  inc = guard;
			// RM_RNE and any undefined code round to nearest even
			default: inc = guard & (sticky | lsb);
		endcase

		sum   = {1'b0, norm[31:8]} + {24'd0, inc};
		carry = sum[24];
		// Leading one at bit 31 means an exponent of bias plus 31
		e_fin = 8'(EXP_BIAS + 31) - {3'd0, lz} + {7'd0, carry};

		if (mag == '0)
			res = '0;
		else if (carry)
			res = {s, e_fin, sum[23:1]};
		else
			res = {s, e_fin, sum[MAN_WID-1:0]};
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			o <= '0;
		else
			o <= res;
	end

endmodule

/* hw/fp_isa_pkg.sv */
/*
 * Instruction set definitions for the floating-point execute unit.
 * Holds the major opcode, the func2 and func1 codes, the instruction
 * word with its two decode views and the decoded operation codes.
 */
package fp_isa_pkg;

	// ==============================
	// Major opcode and func2 codes
	// ==============================
	localparam logic [6:0] OP_FLT2    = 7'h52;
	localparam logic [5:0] FN_FLT1    = 6'h01;
	localparam logic [5:0] FN_FSEQ    = 6'h08;
	localparam logic [5:0] FN_FSNE    = 6'h09;
	localparam logic [5:0] FN_FSLT    = 6'h0A;
	localparam logic [5:0] FN_FSLE    = 6'h0B;
	localparam logic [5:0] FN_FCMP    = 6'h0C;
	localparam logic [5:0] FN_FSCALEB = 6'h10;

	// func1 codes live in the rs2 slot of one-operand instructions
	localparam logic [5:0] FN_FABS    = 6'h00;
	localparam logic [5:0] FN_FNEG    = 6'h01;
	localparam logic [5:0] FN_FSIGN   = 6'h02;
	localparam logic [5:0] FN_ISNAN   = 6'h03;
	localparam logic [5:0] FN_FINITE  = 6'h04;
	localparam logic [5:0] FN_FTOI    = 6'h08;
	localparam logic [5:0] FN_ITOF    = 6'h09;

	// Same 32 bits, read as a two-operand or a one-operand format
	// The f1 view only means something when func2 is FN_FLT1
	typedef union packed {
		struct packed {
			logic [5:0] func2;
			logic       resv;
			logic [5:0] rs2;
			logic [5:0] rs1;
			logic [5:0] rd;
			logic [6:0] opcode;
		} f2;
		struct packed {
			logic [5:0] func2;
			logic       resv;
			logic [5:0] func1;
			logic [5:0] rs1;
			logic [5:0] rd;
			logic [6:0] opcode;
		} f1;
	} instr_t;

	// Decoded operation carried down the pipeline
	typedef enum logic [3:0] {
		OPS_NONE, OPS_FABS, OPS_FNEG, OPS_FSIGN, OPS_ISNAN, OPS_FINITE,
		OPS_FSEQ, OPS_FSNE, OPS_FSLT, OPS_FSLE, OPS_FCMP,
		OPS_FSCALEB, OPS_FTOI, OPS_ITOF
	} op_sel_e;

endpackage

/* hw/fp_scaleb.sv */
/*
 * Scale-by-power-of-two unit.
 * Adds a signed integer to the exponent of a float, saturating to
 * infinity on overflow and flushing to signed zero on underflow.
 */
module fp_scaleb
	import fp_format_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] o
);

	logic               a_s;
	logic [7:0]         a_exp;
	logic [22:0]        a_man;
	logic signed [33:0] e_sum;
	logic [31:0]        res;

	always_comb begin
		a_s   = a[FP_WID-1];
		a_exp = a[30:MAN_WID];
		a_man = a[MAN_WID-1:0];
		// Wide sum so that any 32-bit scale factor cannot wrap
		e_sum = $signed({26'd0, a_exp}) + $signed({{2{b[31]}}, b});

		if (&a_exp) begin
			// NaN and infinity pass untouched
			res = a;
		end else if (a_exp == '0) begin
			// Zero keeps its sign, a subnormal becomes that same signed zero
			res = {a_s, 31'd0};
		end else if (e_sum >= 34'sd255) begin
			res = {a_s, FP_INF_POS[30:0]};
		end else if (e_sum <= 34'sd0) begin
			// Results that would be subnormal flush to zero
			res = {a_s, 31'd0};
		end else begin
			res = {a_s, e_sum[EXP_WID-1:0], a_man};
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			o <= '0;
		else
			o <= res;
	end

endmodule

/* hw/fp_unit.sv */
/*
 * Floating-point execute unit, top level.
 * Decode, four parallel execute units and writeback, with a fixed
 * latency of three cycles and one operation accepted per clock.
 */
module fp_unit
	import fp_isa_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        valid,
	input  logic [31:0] ir,
	input  logic [2:0]  rm,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] o,
	output logic        done
);

	logic        d_valid;
	op_sel_e     d_op;
	logic [2:0]  d_rm;
	logic [31:0] d_a, d_b;
	logic [31:0] abs_o, neg_o, sign_o, class_o, cmp_o;
	logic [31:0] scale_o, f2i_o, i2f_o;

	// ==============================
	// Stage 1
	// ==============================
	fp_decode u_decode (
		.clk(clk), .rst(rst), .valid(valid), .ir(ir), .rm(rm), .a(a), .b(b),
		.d_valid(d_valid), .d_op(d_op), .d_rm(d_rm), .d_a(d_a), .d_b(d_b)
	);

	// ==============================
	// Stage 2
	// ==============================
	fp_cmp_sign u_cmp_sign (
		.clk(clk), .rst(rst), .a(d_a), .b(d_b),
		.abs_o(abs_o), .neg_o(neg_o), .sign_o(sign_o),
		.class_o(class_o), .cmp_o(cmp_o)
	);

	fp_scaleb u_scaleb (.clk(clk), .rst(rst), .a(d_a), .b(d_b), .o(scale_o));

	fp_f2i u_f2i (.clk(clk), .rst(rst), .a(d_a), .o(f2i_o));

	fp_i2f u_i2f (.clk(clk), .rst(rst), .a(d_a), .rm(d_rm), .o(i2f_o));

	// Stage 3, which also holds the op code carry register
	fp_writeback u_writeback (
		.clk(clk), .rst(rst), .x_valid(d_valid), .x_op(d_op),
		.abs_o(abs_o), .neg_o(neg_o), .sign_o(sign_o), .class_o(class_o),
		.cmp_o(cmp_o), .scale_o(scale_o), .f2i_o(f2i_o), .i2f_o(i2f_o),
		.o(o), .done(done)
	);

endmodule

/* hw/fp_writeback.sv */
/*
 * Writeback stage of the floating-point execute unit.
 * Lines the op code up with the unit results, selects one and
 * registers it as the output word together with done.
 */
module fp_writeback
	import fp_isa_pkg::*;
	import fp_format_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              x_valid,
	input  op_sel_e           x_op,
	input  logic [FP_WID-1:0] abs_o,
	input  logic [FP_WID-1:0] neg_o,
	input  logic [FP_WID-1:0] sign_o,
	input  logic [FP_WID-1:0] class_o,
	input  logic [FP_WID-1:0] cmp_o,
	input  logic [FP_WID-1:0] scale_o,
	input  logic [FP_WID-1:0] f2i_o,
	input  logic [FP_WID-1:0] i2f_o,
	output logic [FP_WID-1:0] o,
	output logic              done
);

	logic              w_valid;
	op_sel_e           w_op;
	logic [FP_WID-1:0] sel;

	// ==============================
	// Result select
	// ==============================
	always_comb begin
		case (w_op)
			OPS_FABS:    sel = abs_o;
			OPS_FNEG:    sel = neg_o;
			OPS_FSIGN:   sel = sign_o;
			OPS_ISNAN:   sel = {{(FP_WID-1){1'b0}}, class_o[0]};
			OPS_FINITE:  sel = {{(FP_WID-1){1'b0}}, class_o[1]};
			OPS_FSEQ:    sel = {{(FP_WID-1){1'b0}}, cmp_o[0]};
			OPS_FSNE:    sel = {{(FP_WID-1){1'b0}}, ~cmp_o[0]};
			OPS_FSLT:    sel = {{(FP_WID-1){1'b0}}, cmp_o[1]};
			OPS_FSLE:    sel = {{(FP_WID-1){1'b0}}, cmp_o[2]};
			OPS_FCMP:    sel = cmp_o;
			OPS_FSCALEB: sel = scale_o;
			OPS_FTOI:    sel = f2i_o;
			OPS_ITOF:    sel = i2f_o;
			default:     sel = '0;
		endcase
	end

	// The w_ pair matches the units' own result registers
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			w_valid <= 1'b0;
			w_op    <= OPS_NONE;
			o       <= '0;
			done    <= 1'b0;
		end else begin
			w_valid <= x_valid;
			w_op    <= x_op;
			o       <= sel;
			done    <= w_valid;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the fp_unit testbench with Verilator, runs it and checks the log

verilator --binary --timing --top-module fp_unit_tb -f fp_unit.f -o fp_unit_sim \
	> build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/fp_unit_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation failed"; exit 1; }

cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/fp_unit_tb.sv */
/*
 * Testbench for the floating-point execute unit.
 * Drives LFSR and directed operations, predicts each result with a
 * reference model and checks value and three-cycle latency at done.
 */
module fp_unit_tb
	import fp_isa_pkg::*;
	import fp_format_pkg::*;
();

	// ==============================
	// Run length and timeout
	// ==============================
	localparam int RST_CYC   = 8;
	// Operations per test, in order 24, 120, 120, 48, 48 and 120
	localparam int N_OPS     = 480;
	// Test 1 idles at most four cycles after each of its eight gapped ops
	localparam int GAP_MAX   = 32;
	localparam int DRAIN_CYC = 6;
	localparam int LIMIT     = RST_CYC + N_OPS + GAP_MAX + 6 * DRAIN_CYC + 50;

	// Zeros, infinities, NaNs, unit values, subnormals and the largest normal
	localparam logic [31:0] FSPEC [12] = '{
		32'h00000000, 32'h80000000, 32'h7F800000, 32'hFF800000,
		32'h7FC00000, 32'hFFC00001, 32'h3F800000, 32'hBF800000,
		32'h00000001, 32'h80400000, 32'h7F7FFFFF, 32'h7F800001
	};
	// Limits, values near 2^31 and fractions of magnitude below one
	localparam logic [31:0] F2I_EDGE [6] = '{
		32'h4F000000, 32'hCF000000, 32'hCF000001,
		32'h4EFFFFFF, 32'h3F7FFFFF, 32'hBF000000
	};
	// Integer limits and the ties at 2^24 that need rounding
	localparam logic [31:0] ISPEC [8] = '{
		32'h00000000, 32'h00000001, 32'hFFFFFFFF, 32'h7FFFFFFF,
		32'h80000000, 32'h01000001, 32'h01000003, 32'hFEFFFFFF
	};
	localparam logic [5:0] SIGN_FN [5] = '{FN_FABS, FN_FNEG, FN_FSIGN, FN_ISNAN, FN_FINITE};
	localparam logic [5:0] CMP_FN [5]  = '{FN_FSEQ, FN_FSNE, FN_FSLT, FN_FSLE, FN_FCMP};

	logic        clk = 1'b0;
	logic        rst, valid;
	logic [31:0] ir, a, b, o;
	logic [2:0]  rm;
	logic        done;
	logic [15:0] lfsr = 16'd15062;
	int          cyc = 0;
	int          checks = 0;
	int          errors = 0;
	int          n_ops = 0;
	int          ops_mark = 0;
	int          err_mark = 0;

	// Expected words, due cycles and descriptions of the ops in flight
	logic [31:0] exp_q [$];
	int          due_q [$];
	string       tag_q [$];

	fp_unit u_dut (
		.clk(clk), .rst(rst), .valid(valid), .ir(ir), .rm(rm),
		.a(a), .b(b), .o(o), .done(done)
	);

	always #4 clk = ~clk;

	// ==============================
	// Stimulus helpers
	// ==============================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		// Taps 16, 14, 13 and 11 give a maximal length sequence
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] enc2(input logic [5:0] f2);
		return {f2, 1'b0, 6'd2, 6'd1, 6'd3, OP_FLT2};
	endfunction

	// One-operand words put func1 where rs2 sits
	function automatic logic [31:0] enc1(input logic [5:0] f1);
		return {FN_FLT1, 1'b0, f1, 6'd1, 6'd3, OP_FLT2};
	endfunction

	task automatic send_op(input logic [31:0] w, input logic [2:0] m,
			input logic [31:0] x, input logic [31:0] y);
		@(posedge clk);
		#1;
		valid = 1'b1;
		ir    = w;
		rm    = m;
		a     = x;
		b     = y;
		n_ops++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			valid = 1'b0;
		end
	endtask

	// Waits until every op of the test has come back, then reports it
	task automatic end_test(input int num, input string name);
		@(posedge clk);
		#1;
		valid = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		$display("test %0d %s: %0d ops, %0d errors", num, name, n_ops - ops_mark,
			errors - err_mark);
		ops_mark = n_ops;
		err_mark = errors;
	endtask

	// ==============================
	// Reference model
	// ==============================
	function automatic real pow2(input int n);
		real p;
		p = 1.0;
		for (int i = 0; i < n; i++)
			p = p * 2.0;
		for (int i = 0; i > n; i--)
			p = p / 2.0;
		return p;
	endfunction

	// Subnormals read as signed zero and infinity as a huge finite value
	function automatic real to_real(input logic [31:0] x);
		real m;
		if (x[30:23] == 8'h00)
			m = 0.0;
		else if (x[30:23] == 8'hFF)
			m = 1.0e300;
		else
			m = (1.0 + real'(int'(x[22:0])) / 8388608.0) * pow2(int'(x[30:23]) - 127);
		return x[31] ? -m : m;
	endfunction

	function automatic logic [31:0] fp_to_int(input logic [31:0] x);
		real r;
		logic [31:0] res;
		r = to_real(x);
		if (x[30:23] == 8'hFF && x[22:0] != '0)
			res = INT_MAX;
		else if (r >= 2147483648.0)
			res = INT_MAX;
		else if (r < -2147483648.0)
			res = INT_MIN;
		else
			res = 32'($rtoi(r));
		return res;
	endfunction

	// Splits the magnitude into a 24-bit quotient and a remainder, then rounds
	function automatic logic [31:0] int_to_fp(input logic [31:0] x, input logic [2:0] m);
		longint v, mag, q, rem, half;
		int e;
		logic s, up;
		v   = longint'($signed(x));
		s   = v < 0;
		mag = s ? -v : v;
		if (mag == 0)
			return '0;
		e = 0;
		while ((mag >> (e + 1)) != 0)
			e++;
		if (e <= 23) begin
			q    = mag << (23 - e);
			rem  = 0;
			half = 1;
		end else begin
			q    = mag >> (e - 23);
			rem  = mag - (q << (e - 23));
			half = 64'sd1 << (e - 24);
		end
		case (m)
			RM_RTZ:  up = 1'b0;
			RM_RDN:  up = s && rem != 0;
			RM_RUP:  up = !s && rem != 0;
			RM_RMM:  up = rem >= half;
			default: up = rem > half || (rem == half && q[0]);
		endcase
		if (up)
			q++;
		// Rounding past 2^24 moves the point by one
		if (q == (64'sd1 << 24)) begin
			q = q >> 1;
			e++;
		end
		return {s, 8'(e + 127), q[22:0]};
	endfunction

	function automatic logic [31:0] scale_ref(input logic [31:0] x, input logic [31:0] y);
		longint ne;
		if (x[30:23] == 8'hFF)
			return x;
		if (x[30:23] == 8'h00)
			return {x[31], 31'd0};
		ne = longint'(x[30:23]) + longint'($signed(y));
		if (ne >= 255)
			return {x[31], 8'hFF, 23'd0};
		if (ne <= 0)
			return {x[31], 31'd0};
		return {x[31], 8'(ne), x[22:0]};
	endfunction

	function automatic logic [31:0] fp_ref(input logic [31:0] w, input logic [2:0] m,
			input logic [31:0] x, input logic [31:0] y);
		logic nan_x, nan_y, eq, lt;
		logic [31:0] cmpw, r;
		real rx, ry;
		nan_x = x[30:23] == 8'hFF && x[22:0] != '0;
		nan_y = y[30:23] == 8'hFF && y[22:0] != '0;
		rx    = to_real(x);
		ry    = to_real(y);
		eq    = rx == ry;
		lt    = rx < ry;
		// Bit 4 flags unordered, bits 2 to 0 are le, lt and eq
		if (nan_x || nan_y)
			cmpw = 32'h10;
		else
			cmpw = {29'd0, eq | lt, lt, eq};
		r = '0;
		if (w[6:0] == OP_FLT2) begin
			case (w[31:26])
				FN_FLT1: begin
					case (w[24:19])
						FN_FABS:   r = {1'b0, x[30:0]};
						FN_FNEG:   r = {~x[31], x[30:0]};
						FN_FSIGN:  r = nan_x ? FP_QNAN :
							(x[30:23] == 8'h00) ? {x[31], 31'd0} : {x[31], 31'h3F800000};
						FN_ISNAN:  r = {31'd0, nan_x};
						FN_FINITE: r = {31'd0, x[30:23] != 8'hFF};
						FN_FTOI:   r = fp_to_int(x);
						FN_ITOF:   r = int_to_fp(x, m);
						default:   r = '0;
					endcase
				end
				FN_FSCALEB: r = scale_ref(x, y);
				FN_FSEQ:    r = {31'd0, cmpw[0]};
				FN_FSNE:    r = {31'd0, ~cmpw[0]};
				FN_FSLT:    r = {31'd0, cmpw[1]};
				FN_FSLE:    r = {31'd0, cmpw[2]};
				FN_FCMP:    r = cmpw;
				default:    r = '0;
			endcase
		end
		return r;
	endfunction

	// ==============================
	// Checking
	// ==============================
	task automatic check_val(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL at time %0t: %s, got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	// Outputs and driven inputs are both settled at the falling edge
	always @(negedge clk) begin
		if (done) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Unexpected done at time %0t with no operation in flight", $time);
			end else begin
				check_val({tag_q[0], " latency"}, cyc, due_q[0]);
				check_val(tag_q[0], o, exp_q[0]);
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
				void'(tag_q.pop_front());
			end
		end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
			errors++;
			$display("Missing done at time %0t for %s", $time, tag_q[0]);
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
			void'(tag_q.pop_front());
		end
		// Accepted at the next rising edge, so done shows three falls from now
		if (valid) begin
			exp_q.push_back(fp_ref(ir, rm, a, b));
			due_q.push_back(cyc + 3);
			tag_q.push_back($sformatf("ir %08h rm %0d a %08h b %08h", ir, rm, a, b));
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not finish", cyc);
			$display("Checks failed");
			$finish;
		end
	end

	// ==============================
	// Tests
	// ==============================
	initial begin
		logic [31:0] w, x, y, r, s;
		int e;
		rst   = 1'b1;
		valid = 1'b0;
		ir    = '0;
		rm    = '0;
		a     = '0;
		b     = '0;
		repeat (RST_CYC) @(posedge clk);
		#1;
		rst = 1'b0;
		check_val("done after reset", {31'd0, done}, 32'd0);

		// Back to back first, then with idle gaps
		for (int i = 0; i < 24; i++) begin
			rand_bits(32, x);
			rand_bits(32, y);
			send_op((i % 2 == 0) ? enc1(FN_FNEG) : enc2(FN_FCMP), 3'd0, x, y);
			if (i >= 16) begin
				rand_bits(2, r);
				idle_cycles(1 + int'(r[1:0]));
			end
		end
		end_test(1, "latency and throughput");

		for (int f = 0; f < 5; f++) begin
			for (int i = 0; i < 24; i++) begin
				if (i < 12)
					x = FSPEC[i];
				else
					rand_bits(32, x);
				send_op(enc1(SIGN_FN[f]), 3'd0, x, 32'd0);
			end
		end
		end_test(2, "sign and class");

		// Neighbouring specials pair signed zeros, infinities and NaNs
		for (int f = 0; f < 5; f++) begin
			for (int i = 0; i < 24; i++) begin
				if (i < 12) begin
					x = FSPEC[i];
					y = FSPEC[i ^ 1];
				end else begin
					rand_bits(32, x);
					rand_bits(32, y);
					case (i % 4)
						0: y = x;
						1: y = x ^ 32'd1;
						2: y = x ^ 32'h80000000;
						default: y = y;
					endcase
				end
				send_op(enc2(CMP_FN[f]), 3'd0, x, y);
			end
		end
		end_test(3, "compare");

		// Scale factors aimed at the overflow and flush edges
		for (int i = 0; i < 48; i++) begin
			if (i < 12)
				x = FSPEC[i];
			else
				rand_bits(32, x);
			e = int'(x[30:23]);
			case (i % 6)
				0: begin
					rand_bits(6, y);
					y = {{26{y[5]}}, y[5:0]};
				end
				1: y = 32'(255 - e);
				2: y = 32'(254 - e);
				3: y = 32'(-e);
				4: y = 32'(1 - e);
				default: rand_bits(32, y);
			endcase
			send_op(enc2(FN_FSCALEB), 3'd0, x, y);
		end
		end_test(4, "scale by power of two");

		// Random exponents span fractions, in-range values and saturation
		for (int i = 0; i < 48; i++) begin
			if (i < 12) begin
				x = FSPEC[i];
			end else if (i < 18) begin
				x = F2I_EDGE[i - 12];
			end else begin
				rand_bits(1, s);
				rand_bits(6, r);
				rand_bits(23, y);
				x = {s[0], 8'(32'd120 + r), y[22:0]};
			end
			send_op(enc1(FN_FTOI), 3'd0, x, 32'd0);
		end
		end_test(5, "float to integer");

		for (int m = 0; m < 5; m++) begin
			for (int i = 0; i < 20; i++) begin
				if (i < 8) begin
					x = ISPEC[i];
				end else begin
					rand_bits(32, x);
					rand_bits(5, r);
					x = x >> r[4:0];
					rand_bits(1, s);
					if (s[0])
						x = ~x + 32'd1;
				end
				send_op(enc1(FN_ITOF), 3'(m), x, 32'd0);
			end
		end
		// Rounding codes 5 to 7 are undefined and round to nearest even
		for (int m = 5; m < 8; m++) begin
			for (int i = 0; i < 4; i++)
				send_op(enc1(FN_ITOF), 3'(m), ISPEC[i + 4], 32'd0);
		end
		for (int i = 0; i < 8; i++) begin
			rand_bits(32, x);
			rand_bits(32, y);
			case (i)
				0: w = 32'h0;
				1: w = enc2(6'h3F);
				2: w = enc1(6'h3E);
				3: w = {FN_FSEQ, 1'b0, 18'd0, 7'h53};
				default: begin
					rand_bits(32, w);
					// An odd opcode can never match the float opcode
					w[0] = 1'b1;
				end
			endcase
			send_op(w, 3'd0, x, y);
		end
		end_test(6, "integer to float and undefined words");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
